// File: src/sh_pkg.sv
package sh_pkg;

	typedef logic [31:0] word_t;
	typedef logic [3:0]  reg_num_t;
	typedef logic [15:0] instr_t;

	localparam int NUM_REGS = 16;

	// Canonical SH NOP encoding
	localparam instr_t NOP_INSTR = 16'h0009;

	// Nine operations, so the encoding needs four bits
	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_ADDC,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_PASS,
		ALU_SHL,
		ALU_SHR
	} alu_op_t;

	// How an instruction updates the T bit
	typedef enum logic [2:0] {
		T_KEEP,
		T_EQ,
		T_HS,
		T_GT,
		T_ZERO,
		T_CARRY,
		T_SHIFT
	} t_mode_t;

	// Second operand source
	typedef enum logic {
		IMM_NONE,
		IMM_S8
	} imm_kind_t;

endpackage

// File: src/sh_dec_if.sv
`timescale 1ns/1ps

interface sh_dec_if import sh_pkg::*; ();

	logic      valid;
	alu_op_t   op;
	t_mode_t   t_mode;
	imm_kind_t imm_kind;
	logic [7:0] imm;
	reg_num_t  rn;
	reg_num_t  rm;
	logic      rd_write;
	word_t     a_val;
	word_t     b_val;

	modport src (
		output valid, output op, output t_mode, output imm_kind, output imm,
		output rn, output rm, output rd_write, output a_val, output b_val
	);

	modport dst (
		input valid, input op, input t_mode, input imm_kind, input imm,
		input rn, input rm, input rd_write, input a_val, input b_val
	);

endinterface

// File: src/sh_wb_if.sv
`timescale 1ns/1ps

interface sh_wb_if import sh_pkg::*; ();

	// EX/WB stage contents of the retiring instruction
	logic     valid;
	logic     write;
	reg_num_t num;
	word_t    data;

	modport src (output valid, output write, output num, output data);

	modport sink (input valid, input write, input num, input data);

endinterface

// File: src/sh_regfile.sv
`timescale 1ns/1ps

module sh_regfile import sh_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	sh_wb_if.sink    wb,
	input  reg_num_t ra_num,
	input  reg_num_t rb_num,
	output word_t    ra_val,
	output word_t    rb_val
);

	word_t regs [NUM_REGS];
	logic  wr_en;

	assign wr_en = wb.valid & wb.write;

	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[wb.num] <= wb.data;
		end
	end

	// Write-through covers the instruction two behind a writer
	assign ra_val = (wr_en && wb.num == ra_num) ? wb.data : regs[ra_num];
	assign rb_val = (wr_en && wb.num == rb_num) ? wb.data : regs[rb_num];

endmodule

// File: src/sh_decoder.sv
`timescale 1ns/1ps

module sh_decoder import sh_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     instr_valid,
	input  instr_t   instr,
	output reg_num_t ra_num,
	output reg_num_t rb_num,
	input  word_t    ra_val,
	input  word_t    rb_val,
	sh_dec_if.src    dec
);

	alu_op_t   op;
	t_mode_t   t_mode;
	imm_kind_t imm_kind;
	logic      rd_write;

	// Rn in bits 11:8, Rm in bits 7:4
	assign ra_num = instr[11:8];
	assign rb_num = instr[7:4];

	//**************************************************
	// Instruction decode
	//**************************************************
	always_comb begin
		op       = ALU_PASS;
		t_mode   = T_KEEP;
		imm_kind = IMM_NONE;
		rd_write = 1'b0;
		casez (instr)
			NOP_INSTR: ;
			16'hE???: begin
				imm_kind = IMM_S8;
				rd_write = 1'b1;
			end
			16'h7???: begin
				op       = ALU_ADD;
				imm_kind = IMM_S8;
				rd_write = 1'b1;
			end
			16'h6??3: rd_write = 1'b1;
			16'h3??C: begin
				op       = ALU_ADD;
				rd_write = 1'b1;
			end
			16'h3??E: begin
				op       = ALU_ADDC;
				t_mode   = T_CARRY;
				rd_write = 1'b1;
			end
			16'h3??8: begin
				op       = ALU_SUB;
				t_mode   = T_CARRY;
				rd_write = 1'b1;
			end
			16'h2??9: begin
				op       = ALU_AND;
				rd_write = 1'b1;
			end
			16'h2??B: begin
				op       = ALU_OR;
				rd_write = 1'b1;
			end
			16'h2??A: begin
				op       = ALU_XOR;
				rd_write = 1'b1;
			end
			16'h2??8: t_mode = T_ZERO;
			16'h3??0: t_mode = T_EQ;
			16'h3??2: t_mode = T_HS;
			16'h3??7: t_mode = T_GT;
			16'h4?00: begin
				op       = ALU_SHL;
				t_mode   = T_SHIFT;
				rd_write = 1'b1;
			end
			16'h4?01: begin
				op       = ALU_SHR;
				t_mode   = T_SHIFT;
				rd_write = 1'b1;
			end
			// Unknown encodings fall through as NOP
			default: ;
		endcase
	end

	//**************************************************
	// ID/EX register
	//**************************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			dec.valid    <= 1'b0;
			dec.rd_write <= 1'b0;
		end else begin
			dec.valid <= instr_valid;
			if (instr_valid) begin
				dec.rd_write <= rd_write;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (instr_valid) begin
			dec.op       <= op;
			dec.t_mode   <= t_mode;
			dec.imm_kind <= imm_kind;
			dec.imm      <= instr[7:0];
			dec.rn       <= ra_num;
			dec.rm       <= rb_num;
			dec.a_val    <= ra_val;
			dec.b_val    <= rb_val;
		end
	end

endmodule

// File: src/sh_execute.sv
`timescale 1ns/1ps

module sh_execute import sh_pkg::*; (
	input  logic  CLK,
	input  logic  RST_N,
	sh_dec_if.dst dec,
	sh_wb_if.src  wb,
	output logic  t_flag
);

	logic        fwd;
	word_t       rn_val;
	word_t       rm_val;
	word_t       op_b;
	logic        is_sub;
	logic        carry_in;
	word_t       add_b;
	logic [32:0] add_sum;
	word_t       shift_res;
	logic        shift_out;
	word_t       result;
	logic        t_next;

	//**************************************************
	// Operand bypass and immediate
	//**************************************************
	assign fwd    = wb.valid & wb.write;
	assign rn_val = (fwd && wb.num == dec.rn) ? wb.data : dec.a_val;
	assign rm_val = (fwd && wb.num == dec.rm) ? wb.data : dec.b_val;
	assign op_b   = (dec.imm_kind == IMM_S8) ? {{24{dec.imm[7]}}, dec.imm} : rm_val;

	//**************************************************
	// ALU
	//**************************************************
	// SUB as Rn + ~Rm + 1, carry out is the inverted borrow
	assign is_sub   = (dec.op == ALU_SUB);
	assign add_b    = is_sub ? ~op_b : op_b;
	assign carry_in = is_sub | ((dec.op == ALU_ADDC) & t_flag);
	assign add_sum  = {1'b0, rn_val} + {1'b0, add_b} + {32'd0, carry_in};

	always_comb begin
		if (dec.op == ALU_SHL) begin
			{shift_out, shift_res} = {rn_val, 1'b0};
		end else begin
			{shift_res, shift_out} = {1'b0, rn_val};
		end
	end

	always_comb begin
		case (dec.op)
			ALU_ADD, ALU_ADDC, ALU_SUB: result = add_sum[31:0];
			ALU_AND:                    result = rn_val & op_b;
			ALU_OR:                     result = rn_val | op_b;
			ALU_XOR:                    result = rn_val ^ op_b;
			ALU_SHL, ALU_SHR:           result = shift_res;
			default:                    result = op_b;
		endcase
	end

	always_comb begin
		case (dec.t_mode)
			T_EQ:    t_next = (rn_val == op_b);
			T_HS:    t_next = (rn_val >= op_b);
			T_GT:    t_next = ($signed(rn_val) > $signed(op_b));
			T_ZERO:  t_next = ((rn_val & op_b) == '0);
			T_CARRY: t_next = is_sub ? ~add_sum[32] : add_sum[32];
			T_SHIFT: t_next = shift_out;
			default: t_next = t_flag;
		endcase
	end

	//**************************************************
	// EX/WB register and T
	//**************************************************
	always_ff @(posedge CLK or negedge RST_N) begin
		if (!RST_N) begin
			wb.valid <= 1'b0;
			wb.write <= 1'b0;
			t_flag   <= 1'b0;
		end else begin
			wb.valid <= dec.valid;
			wb.write <= dec.valid & dec.rd_write;
			if (dec.valid) begin
				t_flag <= t_next;
			end
		end
	end

	always_ff @(posedge CLK) begin
		if (dec.valid) begin
			wb.num  <= dec.rn;
			wb.data <= result;
		end
	end

endmodule

// File: src/sh_core.sv
`timescale 1ns/1ps

module sh_core import sh_pkg::*; (
	input  logic     CLK,
	input  logic     RST_N,
	input  logic     instr_valid,
	input  instr_t   instr,
	output logic     retire_valid,
	output logic     rd_write,
	output reg_num_t rd_num,
	output word_t    rd_data,
	output logic     t_flag
);

	reg_num_t ra_num;
	reg_num_t rb_num;
	word_t    ra_val;
	word_t    rb_val;

	sh_dec_if dec_bus ();
	sh_wb_if  wb_bus ();

	sh_regfile regfile_inst (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.wb     (wb_bus.sink),
		.ra_num (ra_num),
		.rb_num (rb_num),
		.ra_val (ra_val),
		.rb_val (rb_val)
	);

	sh_decoder decoder_inst (
		.CLK         (CLK),
		.RST_N       (RST_N),
		.instr_valid (instr_valid),
		.instr       (instr),
		.ra_num      (ra_num),
		.rb_num      (rb_num),
		.ra_val      (ra_val),
		.rb_val      (rb_val),
		.dec         (dec_bus.src)
	);

	sh_execute execute_inst (
		.CLK    (CLK),
		.RST_N  (RST_N),
		.dec    (dec_bus.dst),
		.wb     (wb_bus.src),
		.t_flag (t_flag)
	);

	// Retire strobe is the EX/WB stage
	assign retire_valid = wb_bus.valid;
	assign rd_write     = wb_bus.write;
	assign rd_num       = wb_bus.num;
	assign rd_data      = wb_bus.data;

endmodule

// File: testbench/tb_sh_core.sv
`timescale 1ns/1ps

module tb_sh_core import sh_pkg::*; ();

	logic        CLK;
	logic        RST_N;
	logic        instr_valid;
	instr_t      instr;
	logic        retire_valid;
	logic        rd_write;
	reg_num_t    rd_num;
	word_t       rd_data;
	logic        t_flag;

	// Vectors from the data file, and the instructions in flight
	instr_t      stim_instr[$];
	logic        stim_write[$];
	reg_num_t    stim_num[$];
	word_t       stim_data[$];
	logic        stim_t[$];
	int          fly_idx[$];
	int          fly_cycle[$];
	int          num_lines = 0;
	int          cyc = 0;
	logic [31:0] rnd;

	sh_core sh_core_inst (
		.CLK          (CLK),
		.RST_N        (RST_N),
		.instr_valid  (instr_valid),
		.instr        (instr),
		.retire_valid (retire_valid),
		.rd_write     (rd_write),
		.rd_num       (rd_num),
		.rd_data      (rd_data),
		.t_flag       (t_flag)
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		cyc <= cyc + 1;
	end

	//**************************************************
	// Helpers
	//**************************************************
	function automatic logic [31:0] next_random(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic check_word(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s is %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_reg(input string name, input reg_num_t got, input reg_num_t exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s is %h, expected %h", name, got, exp));
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			report_failure($sformatf("** Error: %s is %h, expected %h", name, got, exp));
		end
	endtask

	task automatic load_testdata();
		int       fd;
		string    line;
		instr_t   f_instr;
		logic     f_write;
		reg_num_t f_num;
		word_t    f_data;
		logic     f_t;
		fd = $fopen("testbench/sh_core_testdata.txt", "r");
		if (fd == 0) begin
			report_failure("Cannot open testbench/sh_core_testdata.txt");
		end else begin
			// Comment lines fail the scan and are skipped
			while ($fgets(line, fd) != 0) begin
				if ($sscanf(line, "%h %h %h %h %h",
						f_instr, f_write, f_num, f_data, f_t) == 5) begin
					stim_instr.push_back(f_instr);
					stim_write.push_back(f_write);
					stim_num.push_back(f_num);
					stim_data.push_back(f_data);
					stim_t.push_back(f_t);
				end
			end
			$fclose(fd);
			if (stim_instr.size() == 0) begin
				report_failure("The test data file holds no vectors");
			end else begin
				num_lines = stim_instr.size();
			end
		end
	endtask

	// Retire must come exactly one cycle after the accepting edge's next edge
	task automatic monitor_outputs();
		int k;
		if (retire_valid) begin
			if (fly_idx.size() == 0) begin
				report_failure("A retire came with no instruction in flight");
			end else if (fly_cycle[0] + 1 != cyc) begin
				report_failure("A retire came at the wrong cycle after its instruction");
			end else begin
				k = fly_idx[0];
				check_flag("rd_write", rd_write, stim_write[k]);
				if (stim_write[k]) begin
					check_reg("rd_num", rd_num, stim_num[k]);
					check_word("rd_data", rd_data, stim_data[k]);
				end
				check_flag("t_flag", t_flag, stim_t[k]);
				void'(fly_idx.pop_front());
				void'(fly_cycle.pop_front());
			end
		end else if (fly_idx.size() != 0 && fly_cycle[0] + 1 <= cyc) begin
			report_failure("No retire two edges after an accepted instruction");
		end
	endtask

	//**************************************************
	// Stimulus
	//**************************************************
	initial begin
		int gap;
		rnd         = 32'd30;
		RST_N       = 1'b0;
		instr_valid = 1'b0;
		instr       = NOP_INSTR;
		load_testdata();
		repeat (2) @(posedge CLK);
		@(negedge CLK);
		RST_N = 1'b1;
		for (int i = 0; i < num_lines; i++) begin
			@(negedge CLK);
			monitor_outputs();
			instr_valid = 1'b1;
			instr       = stim_instr[i];
			fly_idx.push_back(i);
			fly_cycle.push_back(cyc + 1);
			rnd = next_random(rnd);
			gap = int'(rnd % 32'd3);
			// Idle cycles carry junk on instr
			repeat (gap) begin
				@(negedge CLK);
				monitor_outputs();
				instr_valid = 1'b0;
				instr       = rnd[15:0];
			end
		end
		@(negedge CLK);
		monitor_outputs();
		instr_valid = 1'b0;
		repeat (3) begin
			@(negedge CLK);
			monitor_outputs();
		end
		if (fly_idx.size() != 0) begin
			report_failure("Instructions still in flight at the end of the run");
		end else begin
			$display("Test OK");
			$finish;
		end
	end

	initial begin
		wait (num_lines > 0);
		#(num_lines * 5 * 8 + 100);
		report_failure("Timeout, the run did not finish in time");
	end

endmodule

// File: sh_core.f
src/sh_pkg.sv
src/sh_dec_if.sv
src/sh_wb_if.sv
src/sh_regfile.sv
src/sh_decoder.sv
src/sh_execute.sv
src/sh_core.sv
testbench/tb_sh_core.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --top-module tb_sh_core -f sh_core.f -o tb_sh_core &&
./obj_dir/tb_sh_core ||
exit 1

// File: testbench/sh_core_testdata.txt
// instr rd_write rd_num rd_data t_flag (all hex)
E105 1 1 00000005 0
E2FE 1 2 FFFFFFFE 0
7103 1 1 00000008 0
71F0 1 1 FFFFFFF8 0
312C 1 1 FFFFFFF6 0
6313 1 3 FFFFFFF6 0
3328 1 3 FFFFFFF8 1
E47F 1 4 0000007F 1
E50F 1 5 0000000F 1
2459 1 4 0000000F 1
243B 1 4 FFFFFFFF 1
245A 1 4 FFFFFFF0 1
3450 0 0 00000000 0
3550 0 0 00000000 1
3542 0 0 00000000 0
3452 0 0 00000000 1
3457 0 0 00000000 0
3547 0 0 00000000 1
2458 0 0 00000000 1
2558 0 0 00000000 0
E7FF 1 7 FFFFFFFF 0
E801 1 8 00000001 0
378E 1 7 00000000 1
378E 1 7 00000002 0
0009 0 0 00000000 0
E980 1 9 FFFFFF80 0
4900 1 9 FFFFFF00 1
4801 1 8 00000000 1
FFFF 0 0 00000000 1
4901 1 9 7FFFFF80 0
